// ==== rtl/rsv_pkg.sv ====
package rsv_pkg;

    // Dispatch slots per clock. Also the number of read ports.
    localparam int DISPATCH_WIDTH = 4;

    localparam int ROB_ID_W    = 6;
    localparam int BUF_ID_W    = 4;   // Load or store buffer id.
    localparam int PRF_CODE_W  = 7;
    localparam int IMM_W       = 32;
    localparam int EXCP_CODE_W = 5;
    localparam int KIND_W      = 2;

    // Tells which buffer, if any, buf_id points into.
    typedef enum logic [KIND_W-1:0] {
        RSV_KIND_ALU    = 2'd0,
        RSV_KIND_LOAD   = 2'd1,
        RSV_KIND_STORE  = 2'd2,
        RSV_KIND_BRANCH = 2'd3
    } rsv_kind_e;

    // Stored entry, msb first:
    // rob_id, kind, buf_id, dst_vld, prf_code, imm, excp_code.
    localparam int RSV_DATA_W = ROB_ID_W
                              + KIND_W
                              + BUF_ID_W
                              + 1
                              + PRF_CODE_W
                              + IMM_W
                              + EXCP_CODE_W;

endpackage

// ==== rtl/rsv_entry_array.sv ====
`timescale 1ns/1ps

module rsv_entry_array #(
    parameter int NUM_ENTRIES = 64
) (
    input  logic                                                          clk,
    input  logic                                                          i_reset,

    input  logic                                                          i_csr_trap_flush,
    input  logic                                                          i_exu_mis_flush,
    input  logic                                                          i_exu_ls_flush,

    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0]                            i_dsp_vld,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][$clog2(NUM_ENTRIES)-1:0]   i_dsp_entry,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::ROB_ID_W-1:0]     i_dsp_rob_id,
    input  rsv_pkg::rsv_kind_e [rsv_pkg::DISPATCH_WIDTH-1:0]              i_dsp_kind,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::BUF_ID_W-1:0]     i_dsp_buf_id,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0]                            i_dsp_dst_vld,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::PRF_CODE_W-1:0]   i_dsp_prf_code,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::IMM_W-1:0]        i_dsp_imm,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::EXCP_CODE_W-1:0]  i_dsp_excp_code,

    output logic [NUM_ENTRIES-1:0][rsv_pkg::RSV_DATA_W-1:0]               o_entries
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic                                                        flush;
    logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::RSV_DATA_W-1:0] slot_wdat;
    logic [NUM_ENTRIES-1:0]                                      wr_en;
    logic [NUM_ENTRIES-1:0][rsv_pkg::RSV_DATA_W-1:0]             wr_dat;

    assign flush = i_csr_trap_flush | i_exu_mis_flush | i_exu_ls_flush;

    // Pack each slot's payload into one entry word.
    always_comb begin
        for (int s = 0; s < rsv_pkg::DISPATCH_WIDTH; s++) begin
            slot_wdat[s] = {
                i_dsp_rob_id[s],
                i_dsp_kind[s],
                i_dsp_buf_id[s],
                i_dsp_dst_vld[s],
                i_dsp_prf_code[s],
                i_dsp_imm[s],
                i_dsp_excp_code[s]
            };
        end
    end

    // Per-entry write decode. Slots never share an entry.
    always_comb begin
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            wr_en[e]  = 1'b0;
            wr_dat[e] = '0;
            for (int s = 0; s < rsv_pkg::DISPATCH_WIDTH; s++) begin
                if (i_dsp_vld[s] && (i_dsp_entry[s] == IDX_W'(e))) begin
                    wr_en[e]  = 1'b1;
                    wr_dat[e] = slot_wdat[s];
                end
            end
            wr_en[e] = wr_en[e] & ~flush;   // Flush drops the whole cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_entries <= '0;
        end else begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                if (wr_en[e]) begin
                    o_entries[e] <= wr_dat[e];
                end
            end
        end
    end

endmodule

// ==== rtl/rsv_read_port.sv ====
`timescale 1ns/1ps

module rsv_read_port #(
    parameter int NUM_ENTRIES = 64
) (
    input  logic [NUM_ENTRIES-1:0][rsv_pkg::RSV_DATA_W-1:0] i_entries,
    input  logic [NUM_ENTRIES-1:0]                          i_oldest_vec,

    output logic [rsv_pkg::ROB_ID_W-1:0]                    o_rob_id,
    output rsv_pkg::rsv_kind_e                              o_kind,
    output logic [rsv_pkg::BUF_ID_W-1:0]                    o_buf_id,
    output logic                                            o_dst_vld,
    output logic [rsv_pkg::PRF_CODE_W-1:0]                  o_prf_code,
    output logic [rsv_pkg::IMM_W-1:0]                       o_imm,
    output logic [rsv_pkg::EXCP_CODE_W-1:0]                 o_excp_code
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [IDX_W-1:0]                sel_idx;
    logic [rsv_pkg::RSV_DATA_W-1:0] sel_entry;
    logic [rsv_pkg::KIND_W-1:0]     kind_bits;

    // One-hot to index. ORing the indices of set bits is exact for a one-hot vector.
    always_comb begin
        sel_idx = '0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (i_oldest_vec[e]) begin
                sel_idx = sel_idx | IDX_W'(e);
            end
        end
    end

    assign sel_entry = i_entries[sel_idx];

    assign {
        o_rob_id,
        kind_bits,
        o_buf_id,
        o_dst_vld,
        o_prf_code,
        o_imm,
        o_excp_code
    } = sel_entry;

    assign o_kind = rsv_pkg::rsv_kind_e'(kind_bits);   // Every code is a legal kind.

endmodule

// ==== rtl/rsv_data_top.sv ====
`timescale 1ns/1ps

module rsv_data_top #(
    parameter int NUM_ENTRIES = 64
) (
    input  logic                                                          clk,
    input  logic                                                          i_reset,

    input  logic                                                          i_csr_trap_flush,
    input  logic                                                          i_exu_mis_flush,
    input  logic                                                          i_exu_ls_flush,

    // Dispatch write, one element per slot.
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0]                            i_dsp_vld,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][$clog2(NUM_ENTRIES)-1:0]   i_dsp_entry,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::ROB_ID_W-1:0]     i_dsp_rob_id,
    input  rsv_pkg::rsv_kind_e [rsv_pkg::DISPATCH_WIDTH-1:0]              i_dsp_kind,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::BUF_ID_W-1:0]     i_dsp_buf_id,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0]                            i_dsp_dst_vld,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::PRF_CODE_W-1:0]   i_dsp_prf_code,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::IMM_W-1:0]        i_dsp_imm,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::EXCP_CODE_W-1:0]  i_dsp_excp_code,

    // Read select and payload, one element per port.
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][NUM_ENTRIES-1:0]           i_oldest_vec,

    output logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::ROB_ID_W-1:0]     o_rsv_rob_id,
    output rsv_pkg::rsv_kind_e [rsv_pkg::DISPATCH_WIDTH-1:0]              o_rsv_kind,
    output logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::BUF_ID_W-1:0]     o_rsv_buf_id,
    output logic [rsv_pkg::DISPATCH_WIDTH-1:0]                            o_rsv_dst_vld,
    output logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::PRF_CODE_W-1:0]   o_rsv_prf_code,
    output logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::IMM_W-1:0]        o_rsv_imm,
    output logic [rsv_pkg::DISPATCH_WIDTH-1:0][rsv_pkg::EXCP_CODE_W-1:0]  o_rsv_excp_code
);

    logic [NUM_ENTRIES-1:0][rsv_pkg::RSV_DATA_W-1:0] entries;

    rsv_entry_array #(
        .NUM_ENTRIES      (NUM_ENTRIES)
    ) u_array (
        .clk              (clk),
        .i_reset          (i_reset),
        .i_csr_trap_flush (i_csr_trap_flush),
        .i_exu_mis_flush  (i_exu_mis_flush),
        .i_exu_ls_flush   (i_exu_ls_flush),
        .i_dsp_vld        (i_dsp_vld),
        .i_dsp_entry      (i_dsp_entry),
        .i_dsp_rob_id     (i_dsp_rob_id),
        .i_dsp_kind       (i_dsp_kind),
        .i_dsp_buf_id     (i_dsp_buf_id),
        .i_dsp_dst_vld    (i_dsp_dst_vld),
        .i_dsp_prf_code   (i_dsp_prf_code),
        .i_dsp_imm        (i_dsp_imm),
        .i_dsp_excp_code  (i_dsp_excp_code),
        .o_entries        (entries)
    );

    // All ports see the full store.
    for (genvar p = 0; p < rsv_pkg::DISPATCH_WIDTH; p++) begin : g_port
        rsv_read_port #(
            .NUM_ENTRIES  (NUM_ENTRIES)
        ) u_port (
            .i_entries    (entries),
            .i_oldest_vec (i_oldest_vec[p]),
            .o_rob_id     (o_rsv_rob_id[p]),
            .o_kind       (o_rsv_kind[p]),
            .o_buf_id     (o_rsv_buf_id[p]),
            .o_dst_vld    (o_rsv_dst_vld[p]),
            .o_prf_code   (o_rsv_prf_code[p]),
            .o_imm        (o_rsv_imm[p]),
            .o_excp_code  (o_rsv_excp_code[p])
        );
    end

endmodule

// ==== verif/rsv_data_props.sv ====
`timescale 1ns/1ps

module rsv_data_props #(
    parameter int NUM_ENTRIES = 64
) (
    input  logic                                                        clk,
    input  logic                                                        i_reset,
    input  logic                                                        i_csr_trap_flush,
    input  logic                                                        i_exu_mis_flush,
    input  logic                                                        i_exu_ls_flush,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0]                          i_dsp_vld,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][$clog2(NUM_ENTRIES)-1:0] i_dsp_entry,
    input  logic [rsv_pkg::DISPATCH_WIDTH-1:0][NUM_ENTRIES-1:0]         i_oldest_vec,
    input  logic [NUM_ENTRIES-1:0][rsv_pkg::RSV_DATA_W-1:0]             i_entries
);

    int unsigned distinct_errs = 0;
    int unsigned onehot_errs   = 0;
    int unsigned flush_errs    = 0;

    logic flush;
    logic dup_entry;
    logic sel_bad;

    assign flush = i_csr_trap_flush | i_exu_mis_flush | i_exu_ls_flush;

    always_comb begin
        dup_entry = 1'b0;
        sel_bad   = 1'b0;
        for (int s = 0; s < rsv_pkg::DISPATCH_WIDTH; s++) begin
            sel_bad = sel_bad | ~$onehot(i_oldest_vec[s]);
            for (int t = s + 1; t < rsv_pkg::DISPATCH_WIDTH; t++) begin
                if (i_dsp_vld[s] && i_dsp_vld[t] && (i_dsp_entry[s] == i_dsp_entry[t])) begin
                    dup_entry = 1'b1;
                end
            end
        end
    end

    a_distinct: assert property (@(posedge clk) disable iff (i_reset) !dup_entry)
        else begin
            $error("two valid dispatch slots name the same entry");
            distinct_errs++;
        end

    a_onehot: assert property (@(posedge clk) disable iff (i_reset) !sel_bad)
        else begin
            $error("read select vector is not one-hot");
            onehot_errs++;
        end

    // Flushed cycle must leave the store untouched.
    a_flush_hold: assert property (@(posedge clk) disable iff (i_reset) flush |=> $stable(i_entries))
        else begin
            $error("entry store changed in a flushed cycle");
            flush_errs++;
        end

endmodule

bind rsv_data_top rsv_data_props #(
    .NUM_ENTRIES      (NUM_ENTRIES)
) props_i (
    .clk              (clk),
    .i_reset          (i_reset),
    .i_csr_trap_flush (i_csr_trap_flush),
    .i_exu_mis_flush  (i_exu_mis_flush),
    .i_exu_ls_flush   (i_exu_ls_flush),
    .i_dsp_vld        (i_dsp_vld),
    .i_dsp_entry      (i_dsp_entry),
    .i_oldest_vec     (i_oldest_vec),
    .i_entries        (entries)
);

// ==== verif/rsv_data_tb.sv ====
`timescale 1ns/1ps

module rsv_data_tb;

    localparam int NUM_ENTRIES  = 64;
    localparam int DW           = rsv_pkg::DISPATCH_WIDTH;
    localparam int IDX_W        = $clog2(NUM_ENTRIES);
    localparam int ROB_W        = rsv_pkg::ROB_ID_W;
    localparam int KIND_W       = rsv_pkg::KIND_W;
    localparam int BUF_W        = rsv_pkg::BUF_ID_W;
    localparam int PRF_W        = rsv_pkg::PRF_CODE_W;
    localparam int EXC_W        = rsv_pkg::EXCP_CODE_W;
    localparam int DATA_W       = rsv_pkg::RSV_DATA_W;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 800;
    localparam int TEST_CYCLES  = 1200;   // Directed tests plus random traffic, rounded up.
    localparam int MAX_CYCLES   = (RESET_CYCLES + TEST_CYCLES) * 5 / 4;

    logic                          clk = 1'b0;
    logic                          i_reset;
    logic                          i_csr_trap_flush;
    logic                          i_exu_mis_flush;
    logic                          i_exu_ls_flush;
    logic [DW-1:0]                 i_dsp_vld;
    logic [DW-1:0][IDX_W-1:0]      i_dsp_entry;
    logic [DW-1:0][ROB_W-1:0]      i_dsp_rob_id;
    rsv_pkg::rsv_kind_e [DW-1:0]   i_dsp_kind;
    logic [DW-1:0][BUF_W-1:0]      i_dsp_buf_id;
    logic [DW-1:0]                 i_dsp_dst_vld;
    logic [DW-1:0][PRF_W-1:0]      i_dsp_prf_code;
    logic [DW-1:0][31:0]           i_dsp_imm;
    logic [DW-1:0][EXC_W-1:0]      i_dsp_excp_code;
    logic [DW-1:0][NUM_ENTRIES-1:0] i_oldest_vec;

    logic [DW-1:0][ROB_W-1:0]      o_rsv_rob_id;
    rsv_pkg::rsv_kind_e [DW-1:0]   o_rsv_kind;
    logic [DW-1:0][BUF_W-1:0]      o_rsv_buf_id;
    logic [DW-1:0]                 o_rsv_dst_vld;
    logic [DW-1:0][PRF_W-1:0]      o_rsv_prf_code;
    logic [DW-1:0][31:0]           o_rsv_imm;
    logic [DW-1:0][EXC_W-1:0]      o_rsv_excp_code;

    logic [NUM_ENTRIES-1:0][DATA_W-1:0] shadow;   // Expected store contents.
    logic [DATA_W-1:0] words [DW];
    int sel [DW];
    int pick [DW];
    int checks   = 0;
    int errors   = 0;
    int err_mark = 0;
    int cycles   = 0;

    always #10 clk = ~clk;

    rsv_data_top #(
        .NUM_ENTRIES      (NUM_ENTRIES)
    ) dut_i (
        .clk              (clk),
        .i_reset          (i_reset),
        .i_csr_trap_flush (i_csr_trap_flush),
        .i_exu_mis_flush  (i_exu_mis_flush),
        .i_exu_ls_flush   (i_exu_ls_flush),
        .i_dsp_vld        (i_dsp_vld),
        .i_dsp_entry      (i_dsp_entry),
        .i_dsp_rob_id     (i_dsp_rob_id),
        .i_dsp_kind       (i_dsp_kind),
        .i_dsp_buf_id     (i_dsp_buf_id),
        .i_dsp_dst_vld    (i_dsp_dst_vld),
        .i_dsp_prf_code   (i_dsp_prf_code),
        .i_dsp_imm        (i_dsp_imm),
        .i_dsp_excp_code  (i_dsp_excp_code),
        .i_oldest_vec     (i_oldest_vec),
        .o_rsv_rob_id     (o_rsv_rob_id),
        .o_rsv_kind       (o_rsv_kind),
        .o_rsv_buf_id     (o_rsv_buf_id),
        .o_rsv_dst_vld    (o_rsv_dst_vld),
        .o_rsv_prf_code   (o_rsv_prf_code),
        .o_rsv_imm        (o_rsv_imm),
        .o_rsv_excp_code  (o_rsv_excp_code)
    );

    // Field order: rob_id, kind, buf_id, dst_vld, prf_code, imm, excp_code.
    function automatic logic [DATA_W-1:0] pack_slot(input int s);
        return {i_dsp_rob_id[s], i_dsp_kind[s], i_dsp_buf_id[s], i_dsp_dst_vld[s],
                i_dsp_prf_code[s], i_dsp_imm[s], i_dsp_excp_code[s]};
    endfunction

    function automatic logic [DATA_W-1:0] read_word(input int p);
        return {o_rsv_rob_id[p], o_rsv_kind[p], o_rsv_buf_id[p], o_rsv_dst_vld[p],
                o_rsv_prf_code[p], o_rsv_imm[p], o_rsv_excp_code[p]};
    endfunction

    // Expected read of one entry.
    function automatic logic [DATA_W-1:0] expected_entry(input int idx);
        return shadow[idx];
    endfunction

    task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("%-16s %s, %0d mismatches", name,
                 (errors == err_mark) ? "passed" : "FAILED", errors - err_mark);
        err_mark = errors;
    endtask

    task automatic idle_inputs();
        i_dsp_vld        = '0;
        i_csr_trap_flush = 1'b0;
        i_exu_mis_flush  = 1'b0;
        i_exu_ls_flush   = 1'b0;
    endtask

    task automatic drive_slot(input int s, input int idx);
        i_dsp_vld[s]       = 1'b1;
        i_dsp_entry[s]     = IDX_W'(idx);
        i_dsp_rob_id[s]    = ROB_W'($urandom);
        i_dsp_kind[s]      = rsv_pkg::rsv_kind_e'(KIND_W'($urandom));
        i_dsp_buf_id[s]    = BUF_W'($urandom);
        i_dsp_dst_vld[s]   = 1'($urandom);
        i_dsp_prf_code[s]  = PRF_W'($urandom);
        i_dsp_imm[s]       = $urandom;
        i_dsp_excp_code[s] = EXC_W'($urandom);
    endtask

    task automatic select_entry(input int p, input int idx);
        sel[p]               = idx;
        i_oldest_vec[p]      = '0;
        i_oldest_vec[p][idx] = 1'b1;
    endtask

    task automatic raise_flush(input int f);
        case (f)
            0:       i_csr_trap_flush = 1'b1;
            1:       i_exu_mis_flush  = 1'b1;
            default: i_exu_ls_flush   = 1'b1;
        endcase
    endtask

    // Four distinct random entries.
    task automatic pick_entries();
        int  cand;
        bit  dup;
        for (int s = 0; s < DW; s++) begin
            do begin
                cand = $urandom_range(NUM_ENTRIES - 1);
                dup  = 1'b0;
                for (int t = 0; t < s; t++) begin
                    if (pick[t] == cand) dup = 1'b1;
                end
            end while (dup);
            pick[s] = cand;
        end
    endtask

    always @(posedge clk) begin
        if (i_reset) begin
            shadow <= '0;
        end else if (!(i_csr_trap_flush || i_exu_mis_flush || i_exu_ls_flush)) begin
            for (int s = 0; s < DW; s++) begin
                if (i_dsp_vld[s]) shadow[i_dsp_entry[s]] <= pack_slot(s);
            end
        end
    end

    // Every port against the model, every cycle.
    always @(posedge clk) begin
        if (!i_reset) begin
            for (int p = 0; p < DW; p++) begin
                check_value($sformatf("port %0d entry %0d", p, sel[p]), read_word(p),
                            expected_entry(sel[p]));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int target;
        int asrt_errs;
        void'($urandom(80));
        i_reset = 1'b1;
        idle_inputs();
        for (int s = 0; s < DW; s++) begin
            i_dsp_entry[s]     = '0;
            i_dsp_rob_id[s]    = '0;
            i_dsp_kind[s]      = rsv_pkg::RSV_KIND_ALU;
            i_dsp_buf_id[s]    = '0;
            i_dsp_dst_vld[s]   = 1'b0;
            i_dsp_prf_code[s]  = '0;
            i_dsp_imm[s]       = '0;
            i_dsp_excp_code[s] = '0;
            select_entry(s, 0);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        pick_entries();
        for (int p = 0; p < DW; p++) select_entry(p, pick[p]);
        @(posedge clk);
        for (int p = 0; p < DW; p++) check_value("reset read", read_word(p), '0);
        @(negedge clk);
        report_test("reset");

        @(negedge clk);
        target = $urandom_range(NUM_ENTRIES - 1);
        drive_slot(0, target);
        words[0] = pack_slot(0);
        select_entry(0, target);
        @(negedge clk);
        idle_inputs();
        @(posedge clk);
        check_value("single write", read_word(0), words[0]);
        @(negedge clk);
        report_test("single write");

        @(negedge clk);
        pick_entries();
        for (int s = 0; s < DW; s++) begin
            drive_slot(s, pick[s]);
            words[s] = pack_slot(s);
            select_entry(s, pick[s]);
        end
        @(negedge clk);
        idle_inputs();
        @(posedge clk);
        for (int p = 0; p < DW; p++) check_value("four-wide write", read_word(p), words[p]);
        @(negedge clk);
        report_test("four-wide write");

        // Known values first, then a flushed rewrite of the same entries.
        for (int f = 0; f < 3; f++) begin
            @(negedge clk);
            idle_inputs();
            pick_entries();
            for (int s = 0; s < DW; s++) begin
                drive_slot(s, pick[s]);
                words[s] = pack_slot(s);
                select_entry(s, pick[s]);
            end
            @(negedge clk);
            for (int s = 0; s < DW; s++) drive_slot(s, pick[s]);
            raise_flush(f);
            @(negedge clk);
            idle_inputs();
            @(posedge clk);
            for (int p = 0; p < DW; p++) check_value("flushed write", read_word(p), words[p]);
        end
        @(negedge clk);
        report_test("flush");

        @(negedge clk);
        target = $urandom_range(NUM_ENTRIES - 1);
        drive_slot(0, target);
        @(negedge clk);
        idle_inputs();
        drive_slot(2, target);
        words[0] = pack_slot(2);
        select_entry(0, target);
        select_entry(1, target);
        select_entry(2, $urandom_range(NUM_ENTRIES - 1));
        select_entry(3, $urandom_range(NUM_ENTRIES - 1));
        @(negedge clk);
        idle_inputs();
        @(posedge clk);
        check_value("overwrite port 0", read_word(0), words[0]);
        check_value("overwrite port 1", read_word(1), words[0]);
        @(negedge clk);
        report_test("overwrite");

        repeat (RAND_CYCLES) begin
            @(negedge clk);
            idle_inputs();
            pick_entries();
            for (int s = 0; s < DW; s++) begin
                if ($urandom_range(1) == 1) drive_slot(s, pick[s]);
            end
            if ($urandom_range(9) == 0) raise_flush($urandom_range(2));
            for (int p = 0; p < DW; p++) select_entry(p, $urandom_range(NUM_ENTRIES - 1));
        end
        @(negedge clk);
        idle_inputs();
        @(posedge clk);
        @(negedge clk);
        report_test("random traffic");

        @(negedge clk);
        asrt_errs = dut_i.props_i.distinct_errs + dut_i.props_i.onehot_errs
                  + dut_i.props_i.flush_errs;
        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, asrt_errs);
        if (errors == 0 && asrt_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/rsv_pkg.sv
rtl/rsv_entry_array.sv
rtl/rsv_read_port.sv
rtl/rsv_data_top.sv
verif/rsv_data_props.sv
verif/rsv_data_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the reservation station data store testbench with Verilator.
# The run passes only if the log holds no fail message.

cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module rsv_data_tb \
        -f sources.f -o rsv_data_sim &&
    { ./obj_dir/rsv_data_sim +verilator+error+limit+1000 2>&1 | tee sim.log; } &&
    ! grep -q "Something failed" sim.log &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }
